// ==== Makefile ====
# Verilator build and run of the demo board testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= demo_board_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build the testbench, run it and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Regression passed" $(LOG) || (echo "check of $(LOG) failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== demo_board_top.f ====
design/demo_pkg.sv
design/key_debounce.sv
design/mode_ctrl.sv
design/led_indicator.sv
design/output_select.sv
design/demo_board_top.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== design/demo_board_top.sv ====
`timescale 1ns/1ns

module demo_board_top
#(
	parameter int DEBOUNCE_CYCLES = 500000,
	parameter int BLINK_BITS      = 25,
	parameter int MEM_RST_CYCLES  = 16
)
(
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              key_led,    // active low keys
	input  logic                              key_eeprom,
	input  logic                              key_sd,
	input  logic [demo_pkg::SEG_SEL_W-1:0]    rtc_seg_sel,
	input  logic [demo_pkg::SEG_DATA_W-1:0]   rtc_seg_data,
	input  logic [demo_pkg::SEG_SEL_W-1:0]    eeprom_seg_sel,
	input  logic [demo_pkg::SEG_DATA_W-1:0]   eeprom_seg_data,
	input  logic [demo_pkg::SEG_SEL_W-1:0]    sd_seg_sel,
	input  logic [demo_pkg::SEG_DATA_W-1:0]   sd_seg_data,
	input  logic                              pattern_hs,
	input  logic                              pattern_vs,
	input  logic [demo_pkg::RED_W-1:0]        pattern_r,
	input  logic [demo_pkg::GREEN_W-1:0]      pattern_g,
	input  logic [demo_pkg::BLUE_W-1:0]       pattern_b,
	input  logic                              sd_hs,
	input  logic                              sd_vs,
	input  logic [demo_pkg::RED_W-1:0]        sd_r,
	input  logic [demo_pkg::GREEN_W-1:0]      sd_g,
	input  logic [demo_pkg::BLUE_W-1:0]       sd_b,
	input  logic                              cam_hs,
	input  logic                              cam_vs,
	input  logic [demo_pkg::RED_W-1:0]        cam_r,
	input  logic [demo_pkg::GREEN_W-1:0]      cam_g,
	input  logic [demo_pkg::BLUE_W-1:0]       cam_b,
	output logic [demo_pkg::LED_W-1:0]        led,
	output demo_pkg::mode_t                   mode,
	output logic                              buzzer_en,
	output logic                              sd_en,
	output logic                              camera_en,
	output logic                              eeprom_press,
	output logic                              mem_rst_n,
	output logic [demo_pkg::SEG_SEL_W-1:0]    seg_sel,
	output logic [demo_pkg::SEG_DATA_W-1:0]   seg_data,
	output logic                              vga_hs,
	output logic                              vga_vs,
	output logic [demo_pkg::RED_W-1:0]        vga_r,
	output logic [demo_pkg::GREEN_W-1:0]      vga_g,
	output logic [demo_pkg::BLUE_W-1:0]       vga_b
);

	logic press_led;
	logic press_eeprom;
	logic press_sd;

	key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_key_led
	(
		.clk   (clk),
		.rst_n (rst_n),
		.key   (key_led),
		.press (press_led)
	);

	key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_key_eeprom
	(
		.clk   (clk),
		.rst_n (rst_n),
		.key   (key_eeprom),
		.press (press_eeprom)
	);

	key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_key_sd
	(
		.clk   (clk),
		.rst_n (rst_n),
		.key   (key_sd),
		.press (press_sd)
	);

	mode_ctrl #(.MEM_RST_CYCLES(MEM_RST_CYCLES)) u_mode_ctrl
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.press_led    (press_led),
		.press_eeprom (press_eeprom),
		.press_sd     (press_sd),
		.mode         (mode),
		.buzzer_en    (buzzer_en),
		.sd_en        (sd_en),
		.camera_en    (camera_en),
		.eeprom_press (eeprom_press),
		.mem_rst_n    (mem_rst_n)
	);

	led_indicator #(.BLINK_BITS(BLINK_BITS)) u_led_indicator
	(
		.clk   (clk),
		.rst_n (rst_n),
		.mode  (mode),
		.led   (led)
	);

	output_select u_output_select
	(
		.clk             (clk),
		.rst_n           (rst_n),
		.mode            (mode),
		.rtc_seg_sel     (rtc_seg_sel),
		.rtc_seg_data    (rtc_seg_data),
		.eeprom_seg_sel  (eeprom_seg_sel),
		.eeprom_seg_data (eeprom_seg_data),
		.sd_seg_sel      (sd_seg_sel),
		.sd_seg_data     (sd_seg_data),
		.pattern_hs      (pattern_hs),
		.pattern_vs      (pattern_vs),
		.pattern_r       (pattern_r),
		.pattern_g       (pattern_g),
		.pattern_b       (pattern_b),
		.sd_hs           (sd_hs),
		.sd_vs           (sd_vs),
		.sd_r            (sd_r),
		.sd_g            (sd_g),
		.sd_b            (sd_b),
		.cam_hs          (cam_hs),
		.cam_vs          (cam_vs),
		.cam_r           (cam_r),
		.cam_g           (cam_g),
		.cam_b           (cam_b),
		.seg_sel         (seg_sel),
		.seg_data        (seg_data),
		.vga_hs          (vga_hs),
		.vga_vs          (vga_vs),
		.vga_r           (vga_r),
		.vga_g           (vga_g),
		.vga_b           (vga_b)
	);

endmodule

// ==== design/demo_pkg.sv ====
package demo_pkg;

	// board modes, one per push key plus idle
	typedef enum logic [1:0]
	{
		MODE_IDLE      = 2'd0,
		MODE_LED_FLASH = 2'd1,
		MODE_EEPROM    = 2'd2,
		MODE_SD        = 2'd3
	} mode_t;

	// board LEDs
	localparam int LED_W = 4;

	// seven-segment display
	localparam int SEG_SEL_W  = 6; // one select line per digit
	localparam int SEG_DATA_W = 8; // segments a..g plus dp

	// VGA colour channels, RGB565
	localparam int RED_W   = 5;
	localparam int GREEN_W = 6;
	localparam int BLUE_W  = 5;

endpackage

// ==== design/key_debounce.sv ====
`timescale 1ns/1ns

module key_debounce
#(
	parameter int DEBOUNCE_CYCLES = 500000
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic key,   // active low, idles high
	output logic press
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic             key_meta;
	logic             key_sync;
	logic             level;    // accepted key level
	logic [CNT_W-1:0] cnt;

	// two-flop synchroniser, idles high like the key
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			key_meta <= 1'b1;
			key_sync <= 1'b1;
		end
		else
		begin
			key_meta <= key;
			key_sync <= key_meta;
		end
	end

	// count how long the synced value has differed from the accepted level
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			level <= 1'b1;
			cnt   <= '0;
			press <= 1'b0;
		end
		else
		begin
			press <= 1'b0;
			if (key_sync == level)
				cnt <= '0; // bounce back, start over
			else if (cnt == CNT_W'(DEBOUNCE_CYCLES))
			begin
				level <= key_sync;
				cnt   <= '0;
				press <= level & ~key_sync; // accepted fall only
			end
			else
				cnt <= cnt + 1'b1;
		end
	end

endmodule

// ==== design/led_indicator.sv ====
`timescale 1ns/1ns

module led_indicator
#(
	parameter int BLINK_BITS = 25
)
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  demo_pkg::mode_t            mode,
	output logic [demo_pkg::LED_W-1:0] led
);

	import demo_pkg::*;

	localparam int TOP = BLINK_BITS - 1;

	logic [BLINK_BITS-1:0] blink_cnt;

	// free running, wraps
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			blink_cnt <= '0;
		else
			blink_cnt <= blink_cnt + 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			led <= '0;
		else
		begin
			case (mode)
				MODE_LED_FLASH:
					led <= LED_W'(1) << blink_cnt[TOP -: 2]; // running light
				MODE_EEPROM:
					led <= LED_W'(blink_cnt[TOP]);
				MODE_SD:
					led <= LED_W'({2{blink_cnt[TOP]}});
				default:
					led <= {LED_W{blink_cnt[BLINK_BITS-3]}}; // idle, fast blink of all
			endcase
		end
	end

endmodule

// ==== design/mode_ctrl.sv ====
`timescale 1ns/1ns

module mode_ctrl
#(
	parameter int MEM_RST_CYCLES = 16
)
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            press_led,
	input  logic            press_eeprom,
	input  logic            press_sd,
	output demo_pkg::mode_t mode,
	output logic            buzzer_en,
	output logic            sd_en,
	output logic            camera_en,
	output logic            eeprom_press,
	output logic            mem_rst_n
);

	import demo_pkg::*;

	localparam int CNT_W = $clog2(MEM_RST_CYCLES + 1);

	mode_t            next_mode;
	logic             mem_rst_trig;
	logic [CNT_W-1:0] mem_rst_cnt;

	// own key of the current mode is ignored, otherwise led > eeprom > sd
	always_comb
	begin
		next_mode = mode;
		if (press_led && mode != MODE_LED_FLASH)
			next_mode = MODE_LED_FLASH;
		else if (press_eeprom && mode != MODE_EEPROM)
			next_mode = MODE_EEPROM;
		else if (press_sd && mode != MODE_SD)
			next_mode = MODE_SD;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mode <= MODE_IDLE;
		else
			mode <= next_mode;
	end

	// subsystem enables, one cycle behind mode
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			buzzer_en    <= 1'b0;
			sd_en        <= 1'b0;
			camera_en    <= 1'b0;
			eeprom_press <= 1'b0;
		end
		else
		begin
			buzzer_en    <= (mode == MODE_LED_FLASH);
			sd_en        <= (mode == MODE_SD);
			camera_en    <= (mode != MODE_SD); // camera shares memory with sd playback
			eeprom_press <= press_eeprom;      // tester sees the press a cycle late
		end
	end

	// memory controller is reset whenever sd mode is entered or left
	assign mem_rst_trig = (mode == MODE_SD) ? (press_led | press_eeprom) : press_sd;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mem_rst_n <= 1'b0;
		else if (mem_rst_trig)
			mem_rst_n <= 1'b0;
		else if (mem_rst_cnt == CNT_W'(MEM_RST_CYCLES - 1))
			mem_rst_n <= 1'b1;
		else if (mode == MODE_IDLE)
			mem_rst_n <= 1'b1; // nothing uses the memory in idle
	end

	// hold counter, restarts on every new trigger
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mem_rst_cnt <= '0;
		else if (mem_rst_n || mem_rst_trig)
			mem_rst_cnt <= '0;
		else
			mem_rst_cnt <= mem_rst_cnt + 1'b1;
	end

endmodule

// ==== design/output_select.sv ====
`timescale 1ns/1ns

module output_select
(
	input  logic                              clk,
	input  logic                              rst_n,
	input  demo_pkg::mode_t                   mode,
	// seven-segment sources
	input  logic [demo_pkg::SEG_SEL_W-1:0]    rtc_seg_sel,
	input  logic [demo_pkg::SEG_DATA_W-1:0]   rtc_seg_data,
	input  logic [demo_pkg::SEG_SEL_W-1:0]    eeprom_seg_sel,
	input  logic [demo_pkg::SEG_DATA_W-1:0]   eeprom_seg_data,
	input  logic [demo_pkg::SEG_SEL_W-1:0]    sd_seg_sel,
	input  logic [demo_pkg::SEG_DATA_W-1:0]   sd_seg_data,
	// VGA sources
	input  logic                              pattern_hs,
	input  logic                              pattern_vs,
	input  logic [demo_pkg::RED_W-1:0]        pattern_r,
	input  logic [demo_pkg::GREEN_W-1:0]      pattern_g,
	input  logic [demo_pkg::BLUE_W-1:0]       pattern_b,
	input  logic                              sd_hs,
	input  logic                              sd_vs,
	input  logic [demo_pkg::RED_W-1:0]        sd_r,
	input  logic [demo_pkg::GREEN_W-1:0]      sd_g,
	input  logic [demo_pkg::BLUE_W-1:0]       sd_b,
	input  logic                              cam_hs,
	input  logic                              cam_vs,
	input  logic [demo_pkg::RED_W-1:0]        cam_r,
	input  logic [demo_pkg::GREEN_W-1:0]      cam_g,
	input  logic [demo_pkg::BLUE_W-1:0]       cam_b,
	// display outputs
	output logic [demo_pkg::SEG_SEL_W-1:0]    seg_sel,
	output logic [demo_pkg::SEG_DATA_W-1:0]   seg_data,
	output logic                              vga_hs,
	output logic                              vga_vs,
	output logic [demo_pkg::RED_W-1:0]        vga_r,
	output logic [demo_pkg::GREEN_W-1:0]      vga_g,
	output logic [demo_pkg::BLUE_W-1:0]       vga_b
);

	import demo_pkg::*;

	// clock display is the fallback in idle and led flash
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			seg_sel  <= '0;
			seg_data <= '0;
		end
		else if (mode == MODE_EEPROM)
		begin
			seg_sel  <= eeprom_seg_sel;
			seg_data <= eeprom_seg_data;
		end
		else if (mode == MODE_SD)
		begin
			seg_sel  <= sd_seg_sel;
			seg_data <= sd_seg_data;
		end
		else
		begin
			seg_sel  <= rtc_seg_sel;
			seg_data <= rtc_seg_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			{vga_hs, vga_vs, vga_r, vga_g, vga_b} <= '0;
		else if (mode == MODE_IDLE)
			{vga_hs, vga_vs, vga_r, vga_g, vga_b} <= {pattern_hs, pattern_vs, pattern_r,
				pattern_g, pattern_b}; // colour bars
		else if (mode == MODE_SD)
			{vga_hs, vga_vs, vga_r, vga_g, vga_b} <= {sd_hs, sd_vs, sd_r, sd_g, sd_b};
		else
			{vga_hs, vga_vs, vga_r, vga_g, vga_b} <= {cam_hs, cam_vs, cam_r, cam_g, cam_b};
	end

endmodule

// ==== dv/tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker
#(
	parameter int BLINK_BITS     = 6,
	parameter int MEM_RST_CYCLES = 16
)
(
	input  logic            clk,
	input  logic            rst_n,
	input  demo_pkg::mode_t mode,
	input  logic [3:0]      led,
	input  logic            buzzer_en,
	input  logic            sd_en,
	input  logic            camera_en,
	input  logic            eeprom_press,
	input  logic            mem_rst_n,
	input  logic [41:0]     seg_src,  // rtc then eeprom then sd
	input  logic [13:0]     seg_out,
	input  logic [53:0]     vga_src,  // pattern then sd then camera
	input  logic [17:0]     vga_out,
	input  logic            test_done,
	input  int              test_num,
	input  demo_pkg::mode_t exp_mode,
	input  logic            exp_mem_rst,
	input  logic            exp_eeprom,
	input  logic            all_done,
	output int              err_count
);

	import demo_pkg::*;

	logic        started;
	int          cyc;          // cycles since reset release
	mode_t       prev_mode;
	logic [41:0] prev_seg;
	logic [53:0] prev_vga;
	logic        prev_mem;
	int          low_len;
	logic        saw_fall;
	int          ee_pulses;
	int          test_errs;
	int          n_pass;
	int          n_fail;
	logic        closed;

	function automatic logic [3:0] led_expect(input mode_t m, input int cnt);
		int idx;
		idx = (cnt >> (BLINK_BITS - 2)) & 3;
		case (m)
			MODE_LED_FLASH: led_expect = 4'(1 << idx);
			MODE_EEPROM:    led_expect = {3'b000, cnt[BLINK_BITS-1]};
			MODE_SD:        led_expect = {2'b00, cnt[BLINK_BITS-1], cnt[BLINK_BITS-1]};
			default:        led_expect = {4{cnt[BLINK_BITS-3]}};
		endcase
	endfunction

	function automatic logic [13:0] seg_expect(input mode_t m, input logic [41:0] s);
		if (m == MODE_EEPROM)
			seg_expect = s[27:14];
		else if (m == MODE_SD)
			seg_expect = s[13:0];
		else
			seg_expect = s[41:28]; // rtc
	endfunction

	function automatic logic [17:0] vga_expect(input mode_t m, input logic [53:0] v);
		if (m == MODE_IDLE)
			vga_expect = v[53:36];
		else if (m == MODE_SD)
			vga_expect = v[35:18];
		else
			vga_expect = v[17:0]; // camera
	endfunction

	task automatic report_diff(input string name, input logic [63:0] got, input logic [63:0] exp);
		$display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		test_errs++;
	endtask

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			started   = 1'b0;
			cyc       = 0;
			prev_mode = MODE_IDLE;
			prev_mem  = 1'b0;
			low_len   = 0;
			saw_fall  = 1'b0;
			ee_pulses = 0;
			test_errs = 0;
			n_pass    = 0;
			n_fail    = 0;
			err_count = 0;
			closed    = 1'b0;
		end
		else
		begin
			if (started)
			begin
				if (led !== led_expect(prev_mode, cyc - 1))
					report_diff("led", 64'(led), 64'(led_expect(prev_mode, cyc - 1)));
				if (buzzer_en !== (prev_mode == MODE_LED_FLASH))
					report_diff("buzzer_en", 64'(buzzer_en), 64'(prev_mode == MODE_LED_FLASH));
				if (sd_en !== (prev_mode == MODE_SD))
					report_diff("sd_en", 64'(sd_en), 64'(prev_mode == MODE_SD));
				if (camera_en !== (prev_mode != MODE_SD))
					report_diff("camera_en", 64'(camera_en), 64'(prev_mode != MODE_SD));
				// only once the sources have settled
				if (seg_src == prev_seg && seg_out !== seg_expect(prev_mode, prev_seg))
					report_diff("seg", 64'(seg_out), 64'(seg_expect(prev_mode, prev_seg)));
				if (vga_src == prev_vga && vga_out !== vga_expect(prev_mode, prev_vga))
					report_diff("vga", 64'(vga_out), 64'(vga_expect(prev_mode, prev_vga)));
			end

			// memory reset hold length
			if (!mem_rst_n)
			begin
				low_len++;
				if (prev_mem)
					saw_fall = 1'b1;
			end
			else if (low_len > 0)
			begin
				if (prev_mode != MODE_IDLE &&
					(low_len < MEM_RST_CYCLES || low_len > MEM_RST_CYCLES + 2))
				begin
					$display("memory reset held low for %0d cycles, out of range", low_len);
					test_errs++;
				end
				low_len = 0;
			end

			if (eeprom_press)
				ee_pulses++;

			if (test_done)
			begin
				if (mode !== exp_mode)
					report_diff("mode", 64'(mode), 64'(exp_mode));
				if (saw_fall !== exp_mem_rst)
				begin
					$display("memory reset pulse %s", exp_mem_rst ? "expected but not seen"
						: "seen but not expected");
					test_errs++;
				end
				if (ee_pulses != (exp_eeprom ? 1 : 0))
					report_diff("eeprom_press pulses", 64'(ee_pulses), 64'(exp_eeprom));
				if (test_errs == 0)
				begin
					$display("test %0d passed", test_num);
					n_pass++;
				end
				else
				begin
					$display("test %0d failed with %0d errors", test_num, test_errs);
					n_fail++;
				end
				err_count += test_errs;
				test_errs = 0;
				saw_fall  = 1'b0;
				ee_pulses = 0;
			end

			if (all_done && !closed)
			begin
				err_count += test_errs; // anything caught after the last test
				$display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, err_count);
				closed = 1'b1;
			end

			started   = 1'b1;
			prev_mode = mode;
			prev_seg  = seg_src;
			prev_vga  = vga_src;
			prev_mem  = mem_rst_n;
			cyc++;
		end
	end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock
#(
	parameter int PERIOD     = 100,
	parameter int RST_CYCLES = 8
)
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release away from the rising edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;

	import demo_pkg::*;

	localparam int DEBOUNCE_CYCLES = 16;
	localparam int BLINK_BITS      = 6;
	localparam int MEM_RST_CYCLES  = 16;
	localparam int N_ROWS          = 14;
	localparam int TIMEOUT         = 2000;

	localparam logic [2:0] K_LED = 3'b001;
	localparam logic [2:0] K_EE  = 3'b010;
	localparam logic [2:0] K_SD  = 3'b100;

	typedef struct packed
	{
		logic [2:0] keys;     // one bit per key and several for a simultaneous press
		mode_t      exp_mode;
		logic       exp_mem;
		logic [7:0] offset;   // mixed into the source values
	} row_t;

	row_t rows [N_ROWS];

	logic clk, rst_n, key_led, key_eeprom, key_sd;
	logic [5:0] rtc_seg_sel, eeprom_seg_sel, sd_seg_sel;
	logic [7:0] rtc_seg_data, eeprom_seg_data, sd_seg_data;
	logic pattern_hs, pattern_vs, sd_hs, sd_vs, cam_hs, cam_vs;
	logic [4:0] pattern_r, sd_r, cam_r, pattern_b, sd_b, cam_b, vga_r, vga_b;
	logic [5:0] pattern_g, sd_g, cam_g, vga_g;
	logic [3:0] led;
	mode_t mode;
	logic buzzer_en, sd_en, camera_en, eeprom_press, mem_rst_n;
	logic [5:0] seg_sel;
	logic [7:0] seg_data;
	logic vga_hs, vga_vs;
	logic test_done, all_done, exp_mem, exp_ee, timed_out;
	mode_t exp_mode;
	int test_num, err_count;

	tb_clock clk_gen (.clk(clk), .rst_n(rst_n));

	demo_board_top
	#(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.BLINK_BITS      (BLINK_BITS),
		.MEM_RST_CYCLES  (MEM_RST_CYCLES)
	) dut0 (.*);

	tb_checker #(.BLINK_BITS(BLINK_BITS), .MEM_RST_CYCLES(MEM_RST_CYCLES)) chk0
	(
		.clk (clk), .rst_n (rst_n), .mode (mode), .led (led),
		.buzzer_en (buzzer_en), .sd_en (sd_en), .camera_en (camera_en),
		.eeprom_press (eeprom_press), .mem_rst_n (mem_rst_n),
		.seg_src ({rtc_seg_sel, rtc_seg_data, eeprom_seg_sel, eeprom_seg_data,
			sd_seg_sel, sd_seg_data}),
		.seg_out ({seg_sel, seg_data}),
		.vga_src ({pattern_hs, pattern_vs, pattern_r, pattern_g, pattern_b,
			sd_hs, sd_vs, sd_r, sd_g, sd_b, cam_hs, cam_vs, cam_r, cam_g, cam_b}),
		.vga_out ({vga_hs, vga_vs, vga_r, vga_g, vga_b}),
		.test_done (test_done), .test_num (test_num), .exp_mode (exp_mode),
		.exp_mem_rst (exp_mem), .exp_eeprom (exp_ee), .all_done (all_done),
		.err_count (err_count)
	);

	task automatic set_keys(input logic [2:0] keys, input logic level);
		key_led    = keys[0] ? level : 1'b1;
		key_eeprom = keys[1] ? level : 1'b1;
		key_sd     = keys[2] ? level : 1'b1;
	endtask

	task automatic drive_sources(input logic [7:0] offset);
		{rtc_seg_sel, rtc_seg_data}       = 14'($urandom + offset);
		{eeprom_seg_sel, eeprom_seg_data} = 14'($urandom + offset);
		{sd_seg_sel, sd_seg_data}         = 14'($urandom + offset);
		{pattern_hs, pattern_vs, pattern_r, pattern_g, pattern_b} = 18'($urandom ^ offset);
		{sd_hs, sd_vs, sd_r, sd_g, sd_b}  = 18'($urandom ^ offset);
		{cam_hs, cam_vs, cam_r, cam_g, cam_b} = 18'($urandom ^ offset);
	endtask

	// short bounce then a long hold then release and settle
	task automatic press_keys(input logic [2:0] keys);
		set_keys(keys, 1'b0);
		repeat (2) @(negedge clk);
		set_keys(keys, 1'b1);
		repeat (2) @(negedge clk);
		set_keys(keys, 1'b0);
		@(negedge clk);
		set_keys(keys, 1'b1);
		@(negedge clk);
		set_keys(keys, 1'b0);
		repeat (3 * DEBOUNCE_CYCLES) @(negedge clk);
		set_keys(keys, 1'b1);
		repeat (3 * DEBOUNCE_CYCLES) @(negedge clk);
	endtask

	task automatic wait_mode(input mode_t m, output logic ok);
		int n;
		n = 0;
		while (mode !== m && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		ok = (mode === m);
	endtask

	task automatic wait_mem_release(output logic ok);
		int n;
		n = 0;
		while (mem_rst_n !== 1'b1 && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		ok = (mem_rst_n === 1'b1);
	endtask

	initial
	begin
		logic ok;
		int n;
		void'($urandom(83074));
		set_keys(3'b000, 1'b1);
		drive_sources(8'h00);
		{test_done, all_done, exp_mem, exp_ee, timed_out} = '0;
		exp_mode = MODE_IDLE;
		test_num = 0;
		rows[0]  = '{K_SD,        MODE_SD,        1'b1, 8'h11};
		rows[1]  = '{K_SD,        MODE_SD,        1'b0, 8'h22}; // own key ignored
		rows[2]  = '{K_LED,       MODE_LED_FLASH, 1'b1, 8'h33};
		rows[3]  = '{K_LED,       MODE_LED_FLASH, 1'b0, 8'h44};
		rows[4]  = '{K_EE,        MODE_EEPROM,    1'b0, 8'h55};
		rows[5]  = '{K_EE,        MODE_EEPROM,    1'b0, 8'h66};
		rows[6]  = '{K_SD,        MODE_SD,        1'b1, 8'h77};
		rows[7]  = '{K_EE,        MODE_EEPROM,    1'b1, 8'h88};
		rows[8]  = '{K_LED,       MODE_LED_FLASH, 1'b0, 8'h99};
		rows[9]  = '{K_SD,        MODE_SD,        1'b1, 8'haa};
		rows[10] = '{K_LED | K_EE, MODE_LED_FLASH, 1'b1, 8'hbb};
		rows[11] = '{K_EE | K_SD, MODE_EEPROM,    1'b1, 8'hcc}; // sd press still resets memory
		rows[12] = '{K_LED | K_SD, MODE_LED_FLASH, 1'b1, 8'hdd};
		rows[13] = '{K_LED | K_EE | K_SD, MODE_EEPROM, 1'b1, 8'hee};

		n = 0;
		while (rst_n !== 1'b1 && n < 100)
		begin
			@(negedge clk);
			n++;
		end
		if (rst_n !== 1'b1)
		begin
			$display("reset never released");
			timed_out = 1'b1;
		end

		for (int i = 0; i < N_ROWS && !timed_out; i++)
		begin
			@(negedge clk);
			drive_sources(rows[i].offset);
			test_num = i;
			exp_mode = rows[i].exp_mode;
			exp_mem  = rows[i].exp_mem;
			exp_ee   = rows[i].keys[1];
			repeat (2) @(negedge clk);
			press_keys(rows[i].keys);
			wait_mode(rows[i].exp_mode, ok);
			if (!ok)
			begin
				$display("test %0d timed out waiting for mode %0d", i, rows[i].exp_mode);
				timed_out = 1'b1;
			end
			else
			begin
				wait_mem_release(ok);
				if (!ok)
				begin
					$display("test %0d timed out waiting for memory reset release", i);
					timed_out = 1'b1;
				end
			end
			test_done = 1'b1;
			@(negedge clk);
			test_done = 1'b0;
		end

		all_done = 1'b1;
		@(negedge clk);
		if (timed_out || err_count != 0)
			$display("Regression failed");
		else
			$display("Regression passed");
		$finish;
	end

endmodule
